//--- hw/rv32i_types.sv
package rv32i_types;

    localparam int XLEN    = 32;
    localparam int ORDER_W = 64;
    localparam int REG_W   = 5;
    localparam int MASK_W  = XLEN / 8;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    // low three bits follow funct3, bit 3 is funct7[5]
    typedef enum logic [3:0] {
        add_alu  = 4'b0000,
        sll_alu  = 4'b0001,
        slt_alu  = 4'b0010,
        sltu_alu = 4'b0011,
        xor_alu  = 4'b0100,
        srl_alu  = 4'b0101,
        or_alu   = 4'b0110,
        and_alu  = 4'b0111,
        sub_alu  = 4'b1000,
        sra_alu  = 4'b1101
    } alu_ops_t;

    // branch funct3 encoding
    typedef enum logic [2:0] {
        beq_cmp  = 3'b000,
        bne_cmp  = 3'b001,
        blt_cmp  = 3'b100,
        bge_cmp  = 3'b101,
        bltu_cmp = 3'b110,
        bgeu_cmp = 3'b111
    } cmp_ops_t;

    typedef enum logic {
        rs1_v_alu_ex,
        pc_out_alu_ex
    } alu_m1_sel_t;

    typedef enum logic [2:0] {
        i_imm_alu_ex,
        u_imm_alu_ex,
        b_imm_alu_ex,
        s_imm_alu_ex,
        j_imm_alu_ex,
        rs2_v_alu_ex
    } alu_m2_sel_t;

    typedef enum logic {
        rs2_v_cmp_ex,
        i_imm_cmp_ex
    } cmp_m_sel_t;

    typedef enum logic [2:0] {
        lb_mem  = 3'b000,
        lh_mem  = 3'b001,
        lw_mem  = 3'b010,
        lbu_mem = 3'b100,
        lhu_mem = 3'b101
    } load_ops_t;

    typedef enum logic [1:0] {
        sb_mem = 2'b00,
        sh_mem = 2'b01,
        sw_mem = 2'b10
    } store_ops_t;

    typedef enum logic [1:0] {
        alu_out_wb,
        br_en_wb,
        u_imm_wb,
        pc_4_wb
    } wb_m_sel_t;

    typedef struct packed {
        alu_ops_t    alu_ops;
        cmp_ops_t    cmp_ops;
        alu_m1_sel_t alu_m1_sel;
        alu_m2_sel_t alu_m2_sel;
        cmp_m_sel_t  cmp_m_sel;
    } ex_signal_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        load_ops_t  load_ops;
        store_ops_t store_ops;
    } mem_signal_t;

    typedef struct packed {
        logic      regf_we;
        wb_m_sel_t wb_m_sel;
    } wb_signal_t;

    typedef struct packed {
        logic [XLEN-1:0]    inst;
        logic [XLEN-1:0]    pc;
        logic [ORDER_W-1:0] order;
        ex_signal_t         ex_signal;
        mem_signal_t        mem_signal;
        wb_signal_t         wb_signal;
        logic [XLEN-1:0]    i_imm;
        logic [XLEN-1:0]    s_imm;
        logic [XLEN-1:0]    b_imm;
        logic [XLEN-1:0]    u_imm;
        logic [XLEN-1:0]    j_imm;
        logic [XLEN-1:0]    rs1_v;
        logic [XLEN-1:0]    rs2_v;
        logic [REG_W-1:0]   rs1_s;
        logic [REG_W-1:0]   rs2_s;
        logic [REG_W-1:0]   rd_s;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]    inst;
        logic [XLEN-1:0]    pc;
        logic [ORDER_W-1:0] order;
        mem_signal_t        mem_signal;
        wb_signal_t         wb_signal;
        logic [XLEN-1:0]    alu_out;
        logic [XLEN-1:0]    br_en;
        logic [XLEN-1:0]    u_imm;
        logic [XLEN-1:0]    rs1_v;
        logic [XLEN-1:0]    rs2_v;
        logic [REG_W-1:0]   rs1_s;
        logic [REG_W-1:0]   rs2_s;
        logic [REG_W-1:0]   rd_s;
        logic [XLEN-1:0]    mem_addr;
        logic [MASK_W-1:0]  mem_rmask;
        logic [MASK_W-1:0]  mem_wmask;
        logic [XLEN-1:0]    mem_wdata;
    } ex_mem_t;

endpackage

//--- hw/alu.sv
`timescale 1ns/1ns

module alu
import rv32i_types::*;
(
    input  alu_ops_t        aluop,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] f
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            add_alu:  f = a + b;
            sub_alu:  f = a - b;
            sll_alu:  f = a << shamt;
            slt_alu:  f = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            sltu_alu: f = {{(XLEN-1){1'b0}}, a < b};
            xor_alu:  f = a ^ b;
            srl_alu:  f = a >> shamt;
            sra_alu:  f = $unsigned($signed(a) >>> shamt);
            or_alu:   f = a | b;
            and_alu:  f = a & b;
            default:  f = '0;
        endcase
    end

endmodule

//--- hw/cmp.sv
`timescale 1ns/1ns

module cmp
import rv32i_types::*;
(
    input  cmp_ops_t        cmpop,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            br_en
);

    always_comb begin
        case (cmpop)
            beq_cmp:  br_en = (a == b);
            bne_cmp:  br_en = (a != b);
            blt_cmp:  br_en = ($signed(a) < $signed(b));
            bge_cmp:  br_en = ($signed(a) >= $signed(b));
            bltu_cmp: br_en = (a < b);
            bgeu_cmp: br_en = (a >= b);
            default:  br_en = 1'b0;
        endcase
    end

endmodule

//--- hw/stage_reg.sv
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    input  logic     d_valid,
    output payload_t q,
    output logic     q_valid
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= d_valid;
        end
    end

    // payload has no reset, qualified by q_valid
    always_ff @(posedge clk) begin
        q <= d;
    end

    valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(q_valid))
        else $error("stage_reg: q_valid unknown after reset");

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
import rv32i_types::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  logic [XLEN-1:0] inst,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_v,
    input  logic [XLEN-1:0] rs2_v,
    output id_ex_t          id_ex,
    output logic            id_valid
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic               is_slt;
    logic               legal;
    logic [ORDER_W-1:0] order_q;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    // slt and sltu take the comparator result
    assign is_slt = (funct3[2:1] == 2'b01);

    always_comb begin
        id_ex = '0;
        legal = 1'b1;

        id_ex.inst  = inst;
        id_ex.pc    = pc;
        id_ex.order = order_q;
        id_ex.rs1_v = rs1_v;
        id_ex.rs2_v = rs2_v;
        id_ex.rs1_s = inst[19:15];
        id_ex.rs2_s = inst[24:20];
        id_ex.rd_s  = inst[11:7];

        id_ex.i_imm = {{(XLEN-11){inst[31]}}, inst[30:20]};
        id_ex.s_imm = {{(XLEN-11){inst[31]}}, inst[30:25], inst[11:7]};
        id_ex.b_imm = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        id_ex.u_imm = {inst[31:12], 12'h000};
        id_ex.j_imm = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

        id_ex.ex_signal.alu_ops    = add_alu;
        id_ex.ex_signal.cmp_ops    = beq_cmp;
        id_ex.ex_signal.alu_m1_sel = rs1_v_alu_ex;
        id_ex.ex_signal.alu_m2_sel = i_imm_alu_ex;
        id_ex.ex_signal.cmp_m_sel  = rs2_v_cmp_ex;
        id_ex.mem_signal.load_ops  = lw_mem;
        id_ex.mem_signal.store_ops = sw_mem;
        id_ex.wb_signal.wb_m_sel   = alu_out_wb;

        case (opcode)
            op_lui: begin
                id_ex.ex_signal.alu_m2_sel = u_imm_alu_ex;
                id_ex.wb_signal.regf_we    = 1'b1;
                id_ex.wb_signal.wb_m_sel   = u_imm_wb;
            end
            op_auipc: begin
                id_ex.ex_signal.alu_m1_sel = pc_out_alu_ex;
                id_ex.ex_signal.alu_m2_sel = u_imm_alu_ex;
                id_ex.wb_signal.regf_we    = 1'b1;
            end
            op_jal: begin
                id_ex.ex_signal.alu_m1_sel = pc_out_alu_ex;
                id_ex.ex_signal.alu_m2_sel = j_imm_alu_ex;
                id_ex.wb_signal.regf_we    = 1'b1;
                id_ex.wb_signal.wb_m_sel   = pc_4_wb;
            end
            op_jalr: begin
                id_ex.wb_signal.regf_we  = 1'b1;
                id_ex.wb_signal.wb_m_sel = pc_4_wb;
                legal = (funct3 == 3'b000);
            end
            op_br: begin
                // target on the alu, condition on the comparator
                id_ex.ex_signal.alu_m1_sel = pc_out_alu_ex;
                id_ex.ex_signal.alu_m2_sel = b_imm_alu_ex;
                id_ex.ex_signal.cmp_ops    = cmp_ops_t'(funct3);
                legal = (funct3[2:1] != 2'b01);
            end
            op_load: begin
                id_ex.mem_signal.mem_read = 1'b1;
                id_ex.mem_signal.load_ops = load_ops_t'(funct3);
                id_ex.wb_signal.regf_we   = 1'b1;
                legal = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
            end
            op_store: begin
                id_ex.ex_signal.alu_m2_sel  = s_imm_alu_ex;
                id_ex.mem_signal.mem_write  = 1'b1;
                id_ex.mem_signal.store_ops  = store_ops_t'(funct3[1:0]);
                legal = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
            end
            op_imm: begin
                id_ex.ex_signal.alu_ops   = alu_ops_t'({(funct3 == 3'b101) & funct7[5], funct3});
                id_ex.ex_signal.cmp_m_sel = i_imm_cmp_ex;
                id_ex.ex_signal.cmp_ops   = funct3[0] ? bltu_cmp : blt_cmp;
                id_ex.wb_signal.regf_we   = 1'b1;
                id_ex.wb_signal.wb_m_sel  = is_slt ? br_en_wb : alu_out_wb;
            end
            op_reg: begin
                id_ex.ex_signal.alu_ops    = alu_ops_t'({(funct3 == 3'b000 || funct3 == 3'b101)
                                                         & funct7[5], funct3});
                id_ex.ex_signal.alu_m2_sel = rs2_v_alu_ex;
                id_ex.ex_signal.cmp_ops    = funct3[0] ? bltu_cmp : blt_cmp;
                id_ex.wb_signal.regf_we    = 1'b1;
                id_ex.wb_signal.wb_m_sel   = is_slt ? br_en_wb : alu_out_wb;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign id_valid = in_valid & legal;

    // retire order, advanced only by legal instructions
    always_ff @(posedge clk) begin
        if (rst) begin
            order_q <= '0;
        end else if (id_valid) begin
            order_q <= order_q + 1'b1;
        end
    end

endmodule

//--- hw/ex_stage.sv
`timescale 1ns/1ns

module ex_stage
import rv32i_types::*;
(
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);

    logic [XLEN-1:0]   alu_a;
    logic [XLEN-1:0]   alu_b;
    logic [XLEN-1:0]   cmp_b;
    logic [XLEN-1:0]   alu_f;
    logic              br_en;
    logic [MASK_W-1:0] rmask;
    logic [MASK_W-1:0] wmask;
    logic [XLEN-1:0]   wdata;

    assign alu_a = (id_ex.ex_signal.alu_m1_sel == pc_out_alu_ex) ? id_ex.pc : id_ex.rs1_v;
    assign cmp_b = (id_ex.ex_signal.cmp_m_sel == i_imm_cmp_ex) ? id_ex.i_imm : id_ex.rs2_v;

    always_comb begin
        case (id_ex.ex_signal.alu_m2_sel)
            i_imm_alu_ex: alu_b = id_ex.i_imm;
            u_imm_alu_ex: alu_b = id_ex.u_imm;
            b_imm_alu_ex: alu_b = id_ex.b_imm;
            s_imm_alu_ex: alu_b = id_ex.s_imm;
            j_imm_alu_ex: alu_b = id_ex.j_imm;
            rs2_v_alu_ex: alu_b = id_ex.rs2_v;
            default:      alu_b = '0;
        endcase
    end

    alu u_alu (
        .aluop (id_ex.ex_signal.alu_ops),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    cmp u_cmp (
        .cmpop (id_ex.ex_signal.cmp_ops),
        .a     (id_ex.rs1_v),
        .b     (cmp_b),
        .br_en (br_en)
    );

    // byte lanes come from the low bits of the effective address
    always_comb begin
        rmask = '0;
        wmask = '0;
        wdata = '0;
        if (id_ex.mem_signal.mem_read) begin
            case (id_ex.mem_signal.load_ops)
                lb_mem, lbu_mem: rmask = 4'b0001 << alu_f[1:0];
                lh_mem, lhu_mem: rmask = 4'b0011 << alu_f[1:0];
                lw_mem:          rmask = 4'b1111;
                default:         rmask = '0;
            endcase
        end
        if (id_ex.mem_signal.mem_write) begin
            case (id_ex.mem_signal.store_ops)
                sb_mem: begin
                    wmask = 4'b0001 << alu_f[1:0];
                    wdata[8 * alu_f[1:0] +: 8] = id_ex.rs2_v[7:0];
                end
                sh_mem: begin
                    wmask = 4'b0011 << alu_f[1:0];
                    wdata[16 * alu_f[1] +: 16] = id_ex.rs2_v[15:0];
                end
                sw_mem: begin
                    wmask = 4'b1111;
                    wdata = id_ex.rs2_v;
                end
                default: begin
                    wmask = '0;
                end
            endcase
        end
    end

    always_comb begin
        ex_mem.inst       = id_ex.inst;
        ex_mem.pc         = id_ex.pc;
        ex_mem.order      = id_ex.order;
        ex_mem.mem_signal = id_ex.mem_signal;
        ex_mem.wb_signal  = id_ex.wb_signal;
        ex_mem.alu_out    = alu_f;
        ex_mem.br_en      = {{(XLEN-1){1'b0}}, br_en};
        ex_mem.u_imm      = id_ex.u_imm;
        ex_mem.rs1_v      = id_ex.rs1_v;
        ex_mem.rs2_v      = id_ex.rs2_v;
        ex_mem.rs1_s      = id_ex.rs1_s;
        ex_mem.rs2_s      = id_ex.rs2_s;
        ex_mem.rd_s       = id_ex.rd_s;
        ex_mem.mem_addr   = alu_f;
        ex_mem.mem_rmask  = rmask;
        ex_mem.mem_wmask  = wmask;
        ex_mem.mem_wdata  = wdata;
    end

    // a record is a load or a store, never both
    always_comb begin
        if (!$isunknown({rmask, wmask})) begin
            assert (!((|rmask) && (|wmask)))
                else $error("ex_stage: read and write masks both set");
        end
    end

endmodule

//--- hw/exec_core.sv
`timescale 1ns/1ns

module exec_core
import rv32i_types::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  logic [XLEN-1:0]    inst,
    input  logic [XLEN-1:0]    pc,
    input  logic [XLEN-1:0]    rs1_v,
    input  logic [XLEN-1:0]    rs2_v,
    output logic               out_valid,
    output logic [XLEN-1:0]    out_pc,
    output logic [XLEN-1:0]    out_inst,
    output logic [ORDER_W-1:0] out_order,
    output logic [REG_W-1:0]   rd_s,
    output logic               regf_we,
    output logic [XLEN-1:0]    alu_out,
    output logic               br_en,
    output logic [XLEN-1:0]    mem_addr,
    output logic [MASK_W-1:0]  mem_rmask,
    output logic [MASK_W-1:0]  mem_wmask,
    output logic [XLEN-1:0]    mem_wdata
);

    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    logic    id_valid;
    logic    ex_valid;

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .inst     (inst),
        .pc       (pc),
        .rs1_v    (rs1_v),
        .rs2_v    (rs2_v),
        .id_ex    (id_ex_d),
        .id_valid (id_valid)
    );

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk     (clk),
        .rst     (rst),
        .d       (id_ex_d),
        .d_valid (id_valid),
        .q       (id_ex_q),
        .q_valid (ex_valid)
    );

    ex_stage u_ex (
        .id_ex  (id_ex_q),
        .ex_mem (ex_mem_d)
    );

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk     (clk),
        .rst     (rst),
        .d       (ex_mem_d),
        .d_valid (ex_valid),
        .q       (ex_mem_q),
        .q_valid (out_valid)
    );

    assign out_pc    = ex_mem_q.pc;
    assign out_inst  = ex_mem_q.inst;
    assign out_order = ex_mem_q.order;
    assign rd_s      = ex_mem_q.rd_s;
    assign regf_we   = ex_mem_q.wb_signal.regf_we;
    assign alu_out   = ex_mem_q.alu_out;
    assign br_en     = ex_mem_q.br_en[0];
    assign mem_addr  = ex_mem_q.mem_addr;
    assign mem_rmask = ex_mem_q.mem_rmask;
    assign mem_wmask = ex_mem_q.mem_wmask;
    assign mem_wdata = ex_mem_q.mem_wdata;

endmodule

//--- bench/exec_core_tb.sv
`timescale 1ns/1ns

module exec_core_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 8;
    localparam int N_TESTS        = 6;
    localparam int INSTS_PER_TEST = 50;
    localparam int LATENCY        = 2;
    localparam int TIMEOUT_CYCLES = N_TESTS * INSTS_PER_TEST + RESET_CYCLES
                                    + LATENCY * N_TESTS + 100;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [63:0] order;
        logic        we;
        logic [31:0] res;
        logic        chk_br;
        logic        br;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic        chk_wdata;
        logic [31:0] wdata;
        logic [31:0] cycle;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    // a legal addi is presented all through reset
    logic        in_valid = 1'b1;
    logic [31:0] inst = 32'h0050_0093;
    logic [31:0] pc = '0;
    logic [31:0] rs1_v = '0;
    logic [31:0] rs2_v = '0;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_inst;
    logic [63:0] out_order;
    logic [4:0]  rd_s;
    logic        regf_we;
    logic [31:0] alu_out;
    logic        br_en;
    logic [31:0] mem_addr;
    logic [3:0]  mem_rmask;
    logic [3:0]  mem_wmask;
    logic [31:0] mem_wdata;

    exp_t        exp_q[$];
    exp_t        head;
    logic [31:0] rng = 32'd81;
    logic [63:0] next_order = '0;
    logic        idle_check = 1'b1;
    int          cycle = 0;
    int          checks = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          passed = 0;
    int          failed = 0;
    string       test_name = "reset";

    exec_core i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .inst      (inst),
        .pc        (pc),
        .rs1_v     (rs1_v),
        .rs2_v     (rs2_v),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_inst  (out_inst),
        .out_order (out_order),
        .rd_s      (rd_s),
        .regf_we   (regf_we),
        .alu_out   (alu_out),
        .br_en     (br_en),
        .mem_addr  (mem_addr),
        .mem_rmask (mem_rmask),
        .mem_wmask (mem_wmask),
        .mem_wdata (mem_wdata)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic exp_t make_exp(input logic [31:0] w, input logic [31:0] p,
                                      input logic we, input logic [31:0] res,
                                      input logic chk_br, input logic br,
                                      input logic [3:0] rmask, input logic [3:0] wmask,
                                      input logic chk_wdata, input logic [31:0] wdata);
        exp_t e;
        e = '0;
        e.inst      = w;
        e.pc        = p;
        e.we        = we;
        e.res       = res;
        e.chk_br    = chk_br;
        e.br        = br;
        e.rmask     = rmask;
        e.wmask     = wmask;
        e.chk_wdata = chk_wdata;
        e.wdata     = wdata;
        return e;
    endfunction

    task automatic check(input string field, input logic [63:0] expv, input logic [63:0] act);
        checks++;
        assert (expv === act) else begin
            $display("ERR %s %s: expected %h actual %h", test_name, field, expv, act);
            errors++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (idle_check) begin
            checks++;
            assert (out_valid === 1'b0) else begin
                $display("out_valid was high while reset was held or just released");
                errors++;
            end
        end else if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("output appeared with no instruction pending, order %0d", out_order);
                errors++;
            end else begin
                head = exp_q.pop_front();
                check("latency", 64'(head.cycle + LATENCY), 64'(cycle));
                check("inst", 64'(head.inst), 64'(out_inst));
                check("pc", 64'(head.pc), 64'(out_pc));
                check("order", head.order, out_order);
                check("rd_s", 64'(head.inst[11:7]), 64'(rd_s));
                check("regf_we", 64'(head.we), 64'(regf_we));
                check("alu_out", 64'(head.res), 64'(alu_out));
                check("mem_addr", 64'(head.res), 64'(mem_addr));
                check("mem_rmask", 64'(head.rmask), 64'(mem_rmask));
                check("mem_wmask", 64'(head.wmask), 64'(mem_wmask));
                if (head.chk_br) begin
                    check("br_en", 64'(head.br), 64'(br_en));
                end
                if (head.chk_wdata) begin
                    check("mem_wdata", 64'(head.wdata), 64'(mem_wdata));
                end
            end
        end
    end

    task automatic issue(input logic [31:0] w, input logic [31:0] p, input logic [31:0] a,
                         input logic [31:0] b, input logic legal, input exp_t e);
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b1;
        inst     = w;
        pc       = p;
        rs1_v    = a;
        rs2_v    = b;
        if (legal) begin
            e.order = next_order;
            e.cycle = cycle;
            exp_q.push_back(e);
            next_order++;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic report_test();
        if (errors == err_mark) begin
            passed++;
            $display("test %s: ok", test_name);
        end else begin
            failed++;
            $display("test %s: %0d errors", test_name, errors - err_mark);
        end
    endtask

    task automatic end_test();
        idle_cycle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        report_test();
    endtask

    initial begin
        int          i;
        int          k;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] opb;
        logic [31:0] pcv;
        logic [31:0] res;
        logic [31:0] base;
        logic [31:0] wd;
        logic [31:0] w;
        logic [11:0] imm;
        logic [12:0] bimm;
        logic [2:0]  f3;
        logic [2:0]  k3;
        logic [1:0]  off;
        logic [3:0]  mask;
        logic        alt;

        start_test("reset");
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst      = 1'b0;
        in_valid = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        idle_check = 1'b0;
        report_test();

        // register and immediate alu ops, issued back to back
        start_test("alu");
        for (i = 0; i < INSTS_PER_TEST; i++) begin
            r   = xorshift32();
            a   = xorshift32();
            b   = xorshift32();
            pcv = xorshift32() & 32'hffff_fffc;
            f3  = r[2:0];
            if (r[8]) begin
                alt = r[9] && (f3 == 3'b000 || f3 == 3'b101);
                w   = {1'b0, alt, 5'b0, r[14:10], r[19:15], f3, r[24:20], 7'b0110011};
                opb = b;
            end else begin
                imm = r[31:20];
                alt = r[9] && (f3 == 3'b101);
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {1'b0, alt, 5'b0, r[24:20]};
                end
                w   = {imm, r[19:15], f3, r[14:10], 7'b0010011};
                opb = sext12(imm);
            end
            res = alu_model(f3, alt, a, opb);
            issue(w, pcv, a, b, 1'b1,
                  make_exp(w, pcv, 1'b1, res, f3[2:1] == 2'b01, res[0], '0, '0, 1'b0, '0));
        end
        end_test();

        start_test("branch");
        for (i = 0; i < INSTS_PER_TEST; i++) begin
            r    = xorshift32();
            a    = xorshift32();
            b    = (i % 4 == 0) ? a : xorshift32();
            pcv  = xorshift32() & 32'hffff_fffc;
            k3   = 3'(i % 6);
            f3   = (k3 < 3'd2) ? k3 : k3 + 3'd2;
            bimm = {r[12:1], 1'b0};
            w    = {bimm[12], bimm[10:5], r[24:20], r[19:15], f3, bimm[4:1], bimm[11],
                    7'b1100011};
            res  = pcv + {{19{bimm[12]}}, bimm};
            issue(w, pcv, a, b, 1'b1,
                  make_exp(w, pcv, 1'b0, res, 1'b1, branch_model(f3, a, b), '0, '0, 1'b0, '0));
        end
        end_test();

        // every load kind at every aligned lane offset
        start_test("load");
        for (i = 0; i < INSTS_PER_TEST; i++) begin
            r = xorshift32();
            a = xorshift32();
            k = i % 13;
            if (k < 8) begin
                f3   = k[2] ? 3'b100 : 3'b000;
                off  = k[1:0];
                mask = 4'b0001 << off;
            end else if (k < 12) begin
                f3   = (k < 10) ? 3'b001 : 3'b101;
                off  = {k[0], 1'b0};
                mask = 4'b0011 << off;
            end else begin
                f3   = 3'b010;
                off  = 2'b00;
                mask = 4'b1111;
            end
            imm  = r[31:20];
            base = {a[31:2], off};
            w    = {imm, r[19:15], f3, r[24:20], 7'b0000011};
            issue(w, 32'h0000_1000, base - sext12(imm), a, 1'b1,
                  make_exp(w, 32'h0000_1000, 1'b1, base, 1'b0, 1'b0, mask, '0, 1'b0, '0));
        end
        end_test();

        start_test("store");
        for (i = 0; i < INSTS_PER_TEST; i++) begin
            r = xorshift32();
            a = xorshift32();
            b = xorshift32();
            k = i % 7;
            if (k < 4) begin
                f3   = 3'b000;
                off  = k[1:0];
                mask = 4'b0001 << off;
                wd   = {24'b0, b[7:0]} << (8 * off);
            end else if (k < 6) begin
                f3   = 3'b001;
                off  = {k[0], 1'b0};
                mask = 4'b0011 << off;
                wd   = {16'b0, b[15:0]} << (8 * off);
            end else begin
                f3   = 3'b010;
                off  = 2'b00;
                mask = 4'b1111;
                wd   = b;
            end
            imm  = r[31:20];
            base = {a[31:2], off};
            w    = {imm[11:5], r[24:20], r[19:15], f3, imm[4:0], 7'b0100011};
            issue(w, 32'h0000_2000, base - sext12(imm), b, 1'b1,
                  make_exp(w, 32'h0000_2000, 1'b0, base, 1'b0, 1'b0, '0, mask, 1'b1, wd));
        end
        end_test();

        // illegal opcodes become bubbles and leave the order count alone
        start_test("order");
        for (i = 0; i < INSTS_PER_TEST; i++) begin
            r   = xorshift32();
            a   = xorshift32();
            pcv = xorshift32() & 32'hffff_fffc;
            case (r[3:2])
                2'b00, 2'b01: begin
                    imm = r[31:20];
                    w   = {imm, r[19:15], 3'b000, r[11:7], 7'b0010011};
                    res = a + sext12(imm);
                    issue(w, pcv, a, a, 1'b1,
                          make_exp(w, pcv, 1'b1, res, 1'b0, 1'b0, '0, '0, 1'b0, '0));
                end
                2'b10: begin
                    case (r[1:0])
                        2'b00:   w = {r[31:7], 7'b1110011};
                        2'b01:   w = {r[31:7], 7'b0001111};
                        default: w = {r[31:15], 3'b011, r[11:7], 7'b0000011};
                    endcase
                    issue(w, pcv, a, a, 1'b0, '0);
                end
                default: begin
                    idle_cycle();
                end
            endcase
        end
        end_test();

        $display("tests passed %0d failed %0d, checks %0d, errors %0d",
                 passed, failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- list.f
hw/rv32i_types.sv
hw/alu.sv
hw/cmp.sv
hw/stage_reg.sv
hw/decode_stage.sv
hw/ex_stage.sv
hw/exec_core.sv
bench/exec_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module exec_core_tb \
    -f list.f -o exec_core_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/exec_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
exit 1
